// File: rtl/iq_pkg.sv
// Integer issue queue shared definitions
// Queue sizing, slot load selects and the packed dispatch, wakeup, entry and issue records
package iq_pkg;

  localparam int IQ_DEPTH   = 10;
  localparam int TAG_W      = 6;
  localparam int ROB_W      = 6;
  localparam int WAKE_PORTS = 3;

  // Slot load select driven by the collapse controller
  localparam logic [1:0] SEL_HOLD  = 2'd0;
  localparam logic [1:0] SEL_PLUS1 = 2'd1;
  localparam logic [1:0] SEL_PLUS2 = 2'd2;

  typedef logic [TAG_W-1:0] tag_t;

  typedef struct packed {
    logic vld;
    tag_t tag;
  } wakeup_t;

  typedef struct packed {
    logic             vld;
    tag_t             rs1;
    tag_t             rs2;
    logic [ROB_W-1:0] rob;
    logic             rs1_vld;
    logic             rs2_vld;
    logic             rs1_rdy;
    logic             rs2_rdy;
    logic             sc_only;
    logic             mc_only;
  } dispatch_t;

  typedef struct packed {
    logic             vld;
    tag_t             rs1;
    tag_t             rs2;
    logic [ROB_W-1:0] rob;
    logic             rs1_av;
    logic             rs2_av;
    logic             sc_only;
    logic             mc_only;
  } entry_t;

  typedef struct packed {
    tag_t             rs2;
    tag_t             rs1;
    logic [ROB_W-1:0] rob;
  } issue_t;

  // High when the tag matches any valid broadcast of this cycle
  function automatic logic tag_hit(input tag_t tag, input wakeup_t [WAKE_PORTS-1:0] wakeup);
    logic hit;
    hit = 1'b0;
    for (int w = 0; w < WAKE_PORTS; w++) begin
      hit = hit | (wakeup[w].vld & (wakeup[w].tag == tag));
    end
    return hit;
  endfunction

endpackage

// File: rtl/iq_entry.sv
// Issue queue slot
// Holds one entry, wakes its operands and loads from itself or from one or two slots above
`timescale 1ns/100ps

module iq_entry (
  input  logic                                     core_clock_i,
  input  logic                                     rst_i,
  input  logic                                     flush_i,
  input  iq_pkg::wakeup_t [iq_pkg::WAKE_PORTS-1:0] wakeup_i,
  input  logic [1:0]                               shift_sel_i,
  input  iq_pkg::entry_t                           plus1_i,
  input  iq_pkg::entry_t                           plus2_i,
  input  logic                                     grant_i,
  output iq_pkg::entry_t                           next_o,
  output iq_pkg::entry_t                           entry_o,
  output logic                                     ready_o
);

  iq_pkg::entry_t entry_q;
  iq_pkg::entry_t woken;

  // Operand availability after this cycle's broadcasts
  always_comb begin
    woken        = entry_q;
    woken.rs1_av = entry_q.rs1_av | (entry_q.vld & iq_pkg::tag_hit(entry_q.rs1, wakeup_i));
    woken.rs2_av = entry_q.rs2_av | (entry_q.vld & iq_pkg::tag_hit(entry_q.rs2, wakeup_i));
  end

  assign ready_o = entry_q.vld & woken.rs1_av & woken.rs2_av;

  // An issued or flushed entry leaves as a hole, which the slots below may pull in
  always_comb begin
    next_o     = woken;
    next_o.vld = entry_q.vld & ~grant_i & ~flush_i;
  end

  always_ff @(posedge core_clock_i) begin
    case (shift_sel_i)
      iq_pkg::SEL_PLUS1: begin
        entry_q <= plus1_i;
      end
      iq_pkg::SEL_PLUS2: begin
        entry_q <= plus2_i;
      end
      iq_pkg::SEL_HOLD: begin
        entry_q <= next_o;
      end
      default: begin
        entry_q <= next_o;
      end
    endcase
    // Reset empties the slot
    if (rst_i) begin
      entry_q.vld <= 1'b0;
    end
  end

  assign entry_o = entry_q;

endmodule

// File: rtl/iq_collapse_ctrl.sv
// Issue queue collapse controller
// Derives slot shift selects and busy flags from occupancy and forms the dispatched entries
`timescale 1ns/100ps

module iq_collapse_ctrl (
  input  iq_pkg::dispatch_t                        p0_disp_i,
  input  iq_pkg::dispatch_t                        p1_disp_i,
  input  iq_pkg::wakeup_t [iq_pkg::WAKE_PORTS-1:0] wakeup_i,
  input  logic                                     flush_i,
  input  logic [iq_pkg::IQ_DEPTH-1:0]              slot_vld_i,
  output logic [iq_pkg::IQ_DEPTH-1:0][1:0]         shift_sel_o,
  output iq_pkg::entry_t                           new_top_o,
  output iq_pkg::entry_t                           new_second_o,
  output logic                                     p0_busy_o,
  output logic                                     p1_busy_o
);

  // Bit i is set when slots 0 to i hold at least one or at least two holes
  logic [iq_pkg::IQ_DEPTH-1:0] one_hole;
  logic [iq_pkg::IQ_DEPTH-1:0] two_holes;

  always_comb begin
    one_hole[0]  = ~slot_vld_i[0];
    two_holes[0] = 1'b0;
    for (int i = 1; i < iq_pkg::IQ_DEPTH; i++) begin
      one_hole[i]  = one_hole[i-1] | ~slot_vld_i[i];
      two_holes[i] = two_holes[i-1] | (one_hole[i-1] & ~slot_vld_i[i]);
    end
  end

  // A slot moves down by two when two holes sit at or below the slot above it
  always_comb begin
    for (int i = 0; i < iq_pkg::IQ_DEPTH - 1; i++) begin
      if (two_holes[i+1]) begin
        shift_sel_o[i] = iq_pkg::SEL_PLUS2;
      end else if (one_hole[i]) begin
        shift_sel_o[i] = iq_pkg::SEL_PLUS1;
      end else begin
        shift_sel_o[i] = iq_pkg::SEL_HOLD;
      end
    end
    // The top slot takes p1 when two slots are free, and p0 when only one is
    if (two_holes[iq_pkg::IQ_DEPTH-1]) begin
      shift_sel_o[iq_pkg::IQ_DEPTH-1] = iq_pkg::SEL_PLUS1;
    end else if (one_hole[iq_pkg::IQ_DEPTH-1]) begin
      shift_sel_o[iq_pkg::IQ_DEPTH-1] = iq_pkg::SEL_PLUS2;
    end else begin
      shift_sel_o[iq_pkg::IQ_DEPTH-1] = iq_pkg::SEL_HOLD;
    end
  end

  assign p0_busy_o = ~one_hole[iq_pkg::IQ_DEPTH-1];
  assign p1_busy_o = ~two_holes[iq_pkg::IQ_DEPTH-1];

  function automatic iq_pkg::entry_t to_entry(
    input iq_pkg::dispatch_t                        disp,
    input iq_pkg::wakeup_t [iq_pkg::WAKE_PORTS-1:0] wakeup,
    input logic                                     flush
  );
    iq_pkg::entry_t e;
    e.vld     = disp.vld & ~flush;
    e.rs1     = disp.rs1;
    e.rs2     = disp.rs2;
    e.rob     = disp.rob;
    e.rs1_av  = ~disp.rs1_vld | disp.rs1_rdy | iq_pkg::tag_hit(disp.rs1, wakeup);
    e.rs2_av  = ~disp.rs2_vld | disp.rs2_rdy | iq_pkg::tag_hit(disp.rs2, wakeup);
    e.sc_only = disp.sc_only;
    e.mc_only = disp.mc_only;
    return e;
  endfunction

  // p0 is the older of the pair and rides the second-from-top path
  assign new_second_o = to_entry(p0_disp_i, wakeup_i, flush_i);
  assign new_top_o    = to_entry(p1_disp_i, wakeup_i, flush_i);

endmodule

// File: rtl/iq_issue_select.sv
// Issue selector
// Picks the oldest ready entries for the multi-cycle and single-cycle ports and registers them
`timescale 1ns/100ps

module iq_issue_select (
  input  logic                                    core_clock_i,
  input  logic                                    rst_i,
  input  logic                                    flush_i,
  input  iq_pkg::entry_t [iq_pkg::IQ_DEPTH-1:0]   entries_i,
  input  logic [iq_pkg::IQ_DEPTH-1:0]             ready_i,
  input  logic                                    mc_busy_i,
  output logic [iq_pkg::IQ_DEPTH-1:0]             grant_o,
  output logic                                    mc_vld_o,
  output logic                                    sc_vld_o,
  output iq_pkg::issue_t                          mc_data_o,
  output iq_pkg::issue_t                          sc_data_o
);

  logic [iq_pkg::IQ_DEPTH-1:0] sc_only;
  logic [iq_pkg::IQ_DEPTH-1:0] mc_only;
  logic [iq_pkg::IQ_DEPTH-1:0] mc_cand;
  logic [iq_pkg::IQ_DEPTH-1:0] mc_pick;
  logic [iq_pkg::IQ_DEPTH-1:0] sc_cand;
  logic [iq_pkg::IQ_DEPTH-1:0] sc_pick;
  iq_pkg::issue_t              mc_sel;
  iq_pkg::issue_t              sc_sel;

  // Slot 0 is the oldest, so the lowest set request wins
  function automatic logic [iq_pkg::IQ_DEPTH-1:0] oldest(
    input logic [iq_pkg::IQ_DEPTH-1:0] req
  );
    logic [iq_pkg::IQ_DEPTH-1:0] gnt;
    logic                        taken;
    gnt   = '0;
    taken = 1'b0;
    for (int i = 0; i < iq_pkg::IQ_DEPTH; i++) begin
      gnt[i] = req[i] & ~taken;
      taken  = taken | req[i];
    end
    return gnt;
  endfunction

  always_comb begin
    for (int i = 0; i < iq_pkg::IQ_DEPTH; i++) begin
      sc_only[i] = entries_i[i].sc_only;
      mc_only[i] = entries_i[i].mc_only;
    end
  end

  assign mc_cand = ready_i & ~sc_only & {iq_pkg::IQ_DEPTH{~mc_busy_i}};
  assign mc_pick = oldest(mc_cand);
  // The single-cycle pick sees whatever the multi-cycle pick left behind
  assign sc_cand = ready_i & ~mc_only & ~mc_pick;
  assign sc_pick = oldest(sc_cand);
  assign grant_o = mc_pick | sc_pick;

  always_comb begin
    mc_sel = '0;
    sc_sel = '0;
    for (int i = 0; i < iq_pkg::IQ_DEPTH; i++) begin
      if (mc_pick[i]) begin
        mc_sel = '{rs2: entries_i[i].rs2, rs1: entries_i[i].rs1, rob: entries_i[i].rob};
      end
      if (sc_pick[i]) begin
        sc_sel = '{rs2: entries_i[i].rs2, rs1: entries_i[i].rs1, rob: entries_i[i].rob};
      end
    end
  end

  always_ff @(posedge core_clock_i) begin
    if (rst_i || flush_i) begin
      mc_vld_o <= 1'b0;
      sc_vld_o <= 1'b0;
    end else begin
      mc_vld_o <= |mc_pick;
      sc_vld_o <= |sc_pick;
    end
  end

  always_ff @(posedge core_clock_i) begin
    if (|mc_pick) begin
      mc_data_o <= mc_sel;
    end
    if (|sc_pick) begin
      sc_data_o <= sc_sel;
    end
  end

endmodule

// File: rtl/int_issue_queue.sv
// Unified integer issue queue
// Ten age-ordered collapsing slots with dual dispatch and dual oldest-first issue
`timescale 1ns/100ps

module int_issue_queue (
  input  logic                                     core_clock_i,
  input  logic                                     rst_i,
  input  logic                                     flush_i,
  input  iq_pkg::dispatch_t                        p0_disp_i,
  input  iq_pkg::dispatch_t                        p1_disp_i,
  input  iq_pkg::wakeup_t [iq_pkg::WAKE_PORTS-1:0] wakeup_i,
  input  logic                                     mc_busy_i,
  output logic                                     p0_busy_o,
  output logic                                     p1_busy_o,
  output logic                                     mc_vld_o,
  output iq_pkg::issue_t                           mc_data_o,
  output logic                                     sc_vld_o,
  output iq_pkg::issue_t                           sc_data_o
);

  wire iq_pkg::entry_t [iq_pkg::IQ_DEPTH-1:0] next_w;
  wire iq_pkg::entry_t [iq_pkg::IQ_DEPTH-1:0] entry_w;
  wire iq_pkg::entry_t [iq_pkg::IQ_DEPTH-1:0] plus1_w;
  wire iq_pkg::entry_t [iq_pkg::IQ_DEPTH-1:0] plus2_w;
  wire iq_pkg::entry_t                        new_top_w;
  wire iq_pkg::entry_t                        new_second_w;
  wire logic [iq_pkg::IQ_DEPTH-1:0]           slot_vld_w;
  wire logic [iq_pkg::IQ_DEPTH-1:0]           ready_w;
  logic [iq_pkg::IQ_DEPTH-1:0]                grant_w;
  logic [iq_pkg::IQ_DEPTH-1:0][1:0]           shift_sel_w;

  iq_collapse_ctrl u_ctrl (
    .p0_disp_i    (p0_disp_i),
    .p1_disp_i    (p1_disp_i),
    .wakeup_i     (wakeup_i),
    .flush_i      (flush_i),
    .slot_vld_i   (slot_vld_w),
    .shift_sel_o  (shift_sel_w),
    .new_top_o    (new_top_w),
    .new_second_o (new_second_w),
    .p0_busy_o    (p0_busy_o),
    .p1_busy_o    (p1_busy_o)
  );

  for (genvar i = 0; i < iq_pkg::IQ_DEPTH; i++) begin : g_slot
    // The two top slots reach past the end of the queue into the dispatch path
    if (i == iq_pkg::IQ_DEPTH - 1) begin : g_top
      assign plus1_w[i] = new_top_w;
      assign plus2_w[i] = new_second_w;
    end else if (i == iq_pkg::IQ_DEPTH - 2) begin : g_second
      assign plus1_w[i] = next_w[i+1];
      assign plus2_w[i] = new_second_w;
    end else begin : g_body
      assign plus1_w[i] = next_w[i+1];
      assign plus2_w[i] = next_w[i+2];
    end

    assign slot_vld_w[i] = entry_w[i].vld;

    iq_entry u_entry (
      .core_clock_i (core_clock_i),
      .rst_i        (rst_i),
      .flush_i      (flush_i),
      .wakeup_i     (wakeup_i),
      .shift_sel_i  (shift_sel_w[i]),
      .plus1_i      (plus1_w[i]),
      .plus2_i      (plus2_w[i]),
      .grant_i      (grant_w[i]),
      .next_o       (next_w[i]),
      .entry_o      (entry_w[i]),
      .ready_o      (ready_w[i])
    );
  end

  iq_issue_select u_select (
    .core_clock_i (core_clock_i),
    .rst_i        (rst_i),
    .flush_i      (flush_i),
    .entries_i    (entry_w),
    .ready_i      (ready_w),
    .mc_busy_i    (mc_busy_i),
    .grant_o      (grant_w),
    .mc_vld_o     (mc_vld_o),
    .sc_vld_o     (sc_vld_o),
    .mc_data_o    (mc_data_o),
    .sc_data_o    (sc_data_o)
  );

endmodule

// File: tests/int_issue_queue_sva.sv
// Issue queue protocol checks
// Bound to the queue top level to watch the issue valids and the dispatch busy flags
`timescale 1ns/100ps

module int_issue_queue_sva (
  input logic core_clock_i,
  input logic rst_i,
  input logic flush_i,
  input logic mc_busy_i,
  input logic mc_vld_o,
  input logic sc_vld_o,
  input logic p0_busy_o,
  input logic p1_busy_o
);

  // Reset and flush empty both registered issue ports at the next edge
  property clear_empties_issue;
    @(posedge core_clock_i) (rst_i || flush_i) |=> (!mc_vld_o && !sc_vld_o);
  endproperty

  // The multi-cycle unit never gets new work while it reports busy
  property mc_respects_busy;
    @(posedge core_clock_i) disable iff (rst_i) mc_busy_i |=> !$rose(mc_vld_o);
  endproperty

  property busy_flags_ordered;
    @(posedge core_clock_i) disable iff (rst_i) p0_busy_o |-> p1_busy_o;
  endproperty

  assert property (clear_empties_issue)
    else $error("Issue valid high in the cycle after reset or flush");
  assert property (mc_respects_busy)
    else $error("MC issue valid rose in the cycle after mc_busy_i was high");
  assert property (busy_flags_ordered)
    else $error("p0_busy_o high while p1_busy_o low");

endmodule

// File: tests/int_issue_queue_tb.sv
// Integer issue queue testbench
// Drives dispatch, wakeup and MC back-pressure and checks issue and busy against a queue model
`timescale 1ns/100ps

module int_issue_queue_tb;

  localparam int TIMEOUT_CYCLES = 3000;

  logic                                     core_clock;
  logic                                     rst;
  logic                                     flush;
  logic                                     mc_busy;
  iq_pkg::dispatch_t                        p0_disp;
  iq_pkg::dispatch_t                        p1_disp;
  iq_pkg::wakeup_t [iq_pkg::WAKE_PORTS-1:0] wakeup;
  logic                                     p0_busy;
  logic                                     p1_busy;
  logic                                     mc_vld;
  logic                                     sc_vld;
  iq_pkg::issue_t                           mc_data;
  iq_pkg::issue_t                           sc_data;

  // Reference model state, oldest entry at index 0
  iq_pkg::entry_t model_q [iq_pkg::IQ_DEPTH];
  int             model_cnt;
  logic           exp_mc_vld;
  logic           exp_sc_vld;
  logic           exp_p0_busy;
  logic           exp_p1_busy;
  iq_pkg::issue_t exp_mc_data;
  iq_pkg::issue_t exp_sc_data;

  logic        check_en;
  int          errors;
  int          checks;
  int          tests_run;
  int          last_nd;
  int          cycles = 0;
  logic [31:0] rng;
  logic [5:0]  rob_n;

  int_issue_queue uut (
    .core_clock_i (core_clock),
    .rst_i        (rst),
    .flush_i      (flush),
    .p0_disp_i    (p0_disp),
    .p1_disp_i    (p1_disp),
    .wakeup_i     (wakeup),
    .mc_busy_i    (mc_busy),
    .p0_busy_o    (p0_busy),
    .p1_busy_o    (p1_busy),
    .mc_vld_o     (mc_vld),
    .mc_data_o    (mc_data),
    .sc_vld_o     (sc_vld),
    .sc_data_o    (sc_data)
  );

  bind int_issue_queue int_issue_queue_sva u_sva (
    .core_clock_i (core_clock_i),
    .rst_i        (rst_i),
    .flush_i      (flush_i),
    .mc_busy_i    (mc_busy_i),
    .mc_vld_o     (mc_vld_o),
    .sc_vld_o     (sc_vld_o),
    .p0_busy_o    (p0_busy_o),
    .p1_busy_o    (p1_busy_o)
  );

  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  function automatic logic woken_by(input logic [5:0] tag,
                                    input iq_pkg::wakeup_t [iq_pkg::WAKE_PORTS-1:0] wk);
    logic hit;
    hit = 1'b0;
    for (int w = 0; w < iq_pkg::WAKE_PORTS; w++) begin
      if (wk[w].vld && (wk[w].tag == tag)) begin
        hit = 1'b1;
      end
    end
    return hit;
  endfunction

  // A dispatched source counts as available when unused, flagged ready or broadcast now
  function automatic iq_pkg::entry_t disp_entry(input iq_pkg::dispatch_t d,
                                                input iq_pkg::wakeup_t [iq_pkg::WAKE_PORTS-1:0] wk);
    iq_pkg::entry_t e;
    e.vld     = 1'b1;
    e.rs1     = d.rs1;
    e.rs2     = d.rs2;
    e.rob     = d.rob;
    e.rs1_av  = !d.rs1_vld || d.rs1_rdy || woken_by(d.rs1, wk);
    e.rs2_av  = !d.rs2_vld || d.rs2_rdy || woken_by(d.rs2, wk);
    e.sc_only = d.sc_only;
    e.mc_only = d.mc_only;
    return e;
  endfunction

  // Oldest eligible entry to MC unless it is busy, then the oldest remaining one to SC
  function automatic void predict_issue(input logic [iq_pkg::IQ_DEPTH-1:0] rdy,
                                        input logic [iq_pkg::IQ_DEPTH-1:0] sco,
                                        input logic [iq_pkg::IQ_DEPTH-1:0] mco,
                                        input logic busy, output int mc_idx, output int sc_idx);
    mc_idx = -1;
    sc_idx = -1;
    for (int i = 0; i < iq_pkg::IQ_DEPTH; i++) begin
      if (mc_idx < 0 && !busy && rdy[i] && !sco[i]) begin
        mc_idx = i;
      end
    end
    for (int i = 0; i < iq_pkg::IQ_DEPTH; i++) begin
      if (sc_idx < 0 && rdy[i] && !mco[i] && i != mc_idx) begin
        sc_idx = i;
      end
    end
  endfunction

  function automatic iq_pkg::dispatch_t make_disp(input logic [5:0] rs1, input logic [5:0] rs2,
                                                  input logic [5:0] rob, input logic rdy1,
                                                  input logic rdy2, input logic sc,
                                                  input logic mc);
    iq_pkg::dispatch_t d;
    d.vld     = 1'b1;
    d.rs1     = rs1;
    d.rs2     = rs2;
    d.rob     = rob;
    d.rs1_vld = 1'b1;
    d.rs2_vld = 1'b1;
    d.rs1_rdy = rdy1;
    d.rs2_rdy = rdy2;
    d.sc_only = sc;
    d.mc_only = mc;
    return d;
  endfunction

  initial begin
    core_clock = 1'b0;
    forever #4 core_clock = ~core_clock;
  end

  always @(posedge core_clock) begin : model_step
    logic [iq_pkg::IQ_DEPTH-1:0] rdy;
    logic [iq_pkg::IQ_DEPTH-1:0] sco;
    logic [iq_pkg::IQ_DEPTH-1:0] mco;
    int                          mc_idx;
    int                          sc_idx;
    int                          free;
    int                          n;
    iq_pkg::entry_t              kept [iq_pkg::IQ_DEPTH];
    if (rst || flush) begin
      model_cnt  = 0;
      exp_mc_vld = 1'b0;
      exp_sc_vld = 1'b0;
    end else begin
      rdy = '0;
      sco = '0;
      mco = '0;
      for (int i = 0; i < model_cnt; i++) begin
        model_q[i].rs1_av = model_q[i].rs1_av || woken_by(model_q[i].rs1, wakeup);
        model_q[i].rs2_av = model_q[i].rs2_av || woken_by(model_q[i].rs2, wakeup);
        rdy[i] = model_q[i].rs1_av && model_q[i].rs2_av;
        sco[i] = model_q[i].sc_only;
        mco[i] = model_q[i].mc_only;
      end
      predict_issue(rdy, sco, mco, mc_busy, mc_idx, sc_idx);
      free = iq_pkg::IQ_DEPTH - model_cnt;
      exp_mc_vld = (mc_idx >= 0);
      exp_sc_vld = (sc_idx >= 0);
      if (mc_idx >= 0) begin
        exp_mc_data = '{rs2: model_q[mc_idx].rs2, rs1: model_q[mc_idx].rs1,
                        rob: model_q[mc_idx].rob};
      end
      if (sc_idx >= 0) begin
        exp_sc_data = '{rs2: model_q[sc_idx].rs2, rs1: model_q[sc_idx].rs1,
                        rob: model_q[sc_idx].rob};
      end
      n = 0;
      for (int i = 0; i < model_cnt; i++) begin
        if (i != mc_idx && i != sc_idx) begin
          kept[n] = model_q[i];
          n++;
        end
      end
      // Slots free at the start of the cycle decide which dispatches are taken
      if (p0_disp.vld && free >= 1) begin
        kept[n] = disp_entry(p0_disp, wakeup);
        n++;
      end
      if (p1_disp.vld && free >= 2) begin
        kept[n] = disp_entry(p1_disp, wakeup);
        n++;
      end
      for (int i = 0; i < n; i++) begin
        model_q[i] = kept[i];
      end
      model_cnt = n;
    end
    exp_p0_busy = (model_cnt == iq_pkg::IQ_DEPTH);
    exp_p1_busy = (model_cnt >= iq_pkg::IQ_DEPTH - 1);
  end

  always @(negedge core_clock) begin
    if (check_en) begin
      checks++;
      assert (mc_vld === exp_mc_vld && (!exp_mc_vld || mc_data === exp_mc_data)) else begin
        $display("** Error at %0t: MC issue vld %b data %h, expected vld %b data %h",
                 $time, mc_vld, mc_data, exp_mc_vld, exp_mc_data);
        errors++;
      end
      assert (sc_vld === exp_sc_vld && (!exp_sc_vld || sc_data === exp_sc_data)) else begin
        $display("** Error at %0t: SC issue vld %b data %h, expected vld %b data %h",
                 $time, sc_vld, sc_data, exp_sc_vld, exp_sc_data);
        errors++;
      end
      assert (p0_busy === exp_p0_busy && p1_busy === exp_p1_busy) else begin
        $display("** Error at %0t: busy p0 %b p1 %b, expected p0 %b p1 %b",
                 $time, p0_busy, p1_busy, exp_p0_busy, exp_p1_busy);
        errors++;
      end
    end
  end

  always @(posedge core_clock) begin
    cycles++;
    if (cycles >= TIMEOUT_CYCLES) begin
      $display("Timeout after %0d cycles, the run did not complete", cycles);
      $display("Verification failed");
      $finish;
    end
  end

  // Inputs change on the rising edge and the task returns at the falling edge
  task automatic drive_cycle(input iq_pkg::dispatch_t d0, input iq_pkg::dispatch_t d1,
                             input iq_pkg::wakeup_t [iq_pkg::WAKE_PORTS-1:0] wk,
                             input logic busy, input logic fl);
    @(posedge core_clock);
    p0_disp <= d0;
    p1_disp <= d1;
    wakeup  <= wk;
    mc_busy <= busy;
    flush   <= fl;
    last_nd = int'(d0.vld) + int'(d1.vld);
    @(negedge core_clock);
  endtask

  task automatic idle(input int n, input logic busy);
    repeat (n) begin
      drive_cycle('0, '0, '0, busy, 1'b0);
    end
  endtask

  task automatic finish_test(input string name, input int err_before);
    tests_run++;
    $display("Test %0d %s finished with %0d errors", tests_run, name, errors - err_before);
  endtask

  task automatic random_traffic(input int n);
    iq_pkg::dispatch_t                        d0;
    iq_pkg::dispatch_t                        d1;
    iq_pkg::wakeup_t [iq_pkg::WAKE_PORTS-1:0] wk;
    int                                       free;
    logic                                     sc;
    for (int c = 0; c < n; c++) begin
      d0 = '0;
      d1 = '0;
      // Upper bound on occupancy, since pending issues can only free slots
      free = iq_pkg::IQ_DEPTH - model_cnt - last_nd;
      rng = xorshift32(rng);
      sc = rng[15] & rng[16];
      if (free >= 1 && (rng[0] | rng[1])) begin
        d0 = make_disp({1'b0, rng[7:3]}, {1'b0, rng[12:8]}, rob_n, rng[13], rng[14], sc,
                       rng[17] & rng[18] & ~sc);
        // Some sources are unused and count as available at dispatch
        d0.rs1_vld = ~(rng[19] & rng[20]);
        d0.rs2_vld = ~(rng[21] & rng[22]);
        rob_n = rob_n + 6'd1;
      end
      rng = xorshift32(rng);
      sc = rng[15] & rng[16];
      if (free >= 2 && d0.vld && rng[0]) begin
        d1 = make_disp({1'b0, rng[7:3]}, {1'b0, rng[12:8]}, rob_n, rng[13], rng[14], sc,
                       rng[17] & rng[18] & ~sc);
        d1.rs1_vld = ~(rng[19] & rng[20]);
        d1.rs2_vld = ~(rng[21] & rng[22]);
        rob_n = rob_n + 6'd1;
      end
      rng = xorshift32(rng);
      for (int w = 0; w < iq_pkg::WAKE_PORTS; w++) begin
        wk[w].vld = rng[w];
        wk[w].tag = {1'b0, rng[8*w+8 +: 5]};
      end
      drive_cycle(d0, d1, wk, rng[30] & ~rng[31], 1'b0);
    end
  endtask

  initial begin
    iq_pkg::wakeup_t [iq_pkg::WAKE_PORTS-1:0] wk;
    int                                       e0;
    rst       = 1'b1;
    flush     = 1'b0;
    mc_busy   = 1'b0;
    p0_disp   = '0;
    p1_disp   = '0;
    wakeup    = '0;
    model_cnt = 0;
    check_en  = 1'b0;
    errors    = 0;
    checks    = 0;
    tests_run = 0;
    last_nd   = 0;
    rng       = 32'h808c_bef2;
    rob_n     = 6'd20;
    repeat (16) @(posedge core_clock);
    rst <= 1'b0;
    @(negedge core_clock);
    check_en = 1'b1;

    e0 = errors;
    drive_cycle(make_disp(6'd1, 6'd2, 6'd1, 1'b1, 1'b1, 1'b0, 1'b0), '0, '0, 1'b0, 1'b0);
    idle(4, 1'b0);
    drive_cycle(make_disp(6'd3, 6'd4, 6'd2, 1'b1, 1'b1, 1'b1, 1'b0), '0, '0, 1'b0, 1'b0);
    idle(4, 1'b0);
    finish_test("ready dispatch", e0);

    // Four entries wait on tag 10 and wake together
    e0 = errors;
    drive_cycle(make_disp(6'd10, 6'd11, 6'd5, 1'b0, 1'b1, 1'b0, 1'b0),
                make_disp(6'd10, 6'd12, 6'd6, 1'b0, 1'b1, 1'b1, 1'b0), '0, 1'b0, 1'b0);
    drive_cycle(make_disp(6'd10, 6'd13, 6'd7, 1'b0, 1'b1, 1'b0, 1'b1),
                make_disp(6'd10, 6'd14, 6'd8, 1'b0, 1'b1, 1'b0, 1'b0), '0, 1'b0, 1'b0);
    wk = '0;
    wk[0] = '{vld: 1'b1, tag: 6'd10};
    drive_cycle('0, '0, wk, 1'b0, 1'b0);
    idle(6, 1'b0);
    finish_test("oldest first", e0);

    e0 = errors;
    drive_cycle(make_disp(6'd20, 6'd21, 6'd9, 1'b0, 1'b0, 1'b0, 1'b0),
                make_disp(6'd22, 6'd23, 6'd10, 1'b0, 1'b1, 1'b0, 1'b0), '0, 1'b0, 1'b0);
    idle(2, 1'b0);
    wk = '0;
    wk[1] = '{vld: 1'b1, tag: 6'd20};
    wk[2] = '{vld: 1'b1, tag: 6'd21};
    drive_cycle('0, '0, wk, 1'b0, 1'b0);
    idle(2, 1'b0);
    wk = '0;
    wk[0] = '{vld: 1'b1, tag: 6'd22};
    wk[2] = '{vld: 1'b1, tag: 6'd24};
    drive_cycle(make_disp(6'd24, 6'd25, 6'd11, 1'b0, 1'b1, 1'b0, 1'b0), '0, wk, 1'b0, 1'b0);
    idle(5, 1'b0);
    finish_test("wakeup", e0);

    e0 = errors;
    drive_cycle(make_disp(6'd30, 6'd31, 6'd12, 1'b1, 1'b1, 1'b0, 1'b0),
                make_disp(6'd32, 6'd33, 6'd13, 1'b1, 1'b1, 1'b0, 1'b1), '0, 1'b1, 1'b0);
    drive_cycle(make_disp(6'd34, 6'd35, 6'd14, 1'b1, 1'b1, 1'b0, 1'b0),
                make_disp(6'd36, 6'd37, 6'd15, 1'b1, 1'b1, 1'b1, 1'b0), '0, 1'b1, 1'b0);
    idle(6, 1'b1);
    idle(4, 1'b0);
    finish_test("mc busy", e0);

    e0 = errors;
    random_traffic(150);
    idle(12, 1'b0);
    finish_test("random fill", e0);

    e0 = errors;
    random_traffic(20);
    drive_cycle(make_disp(6'd40, 6'd41, 6'd16, 1'b1, 1'b1, 1'b0, 1'b0), '0, '0, 1'b0, 1'b1);
    idle(1, 1'b0);
    assert (!mc_vld && !sc_vld && !p0_busy && !p1_busy) else begin
      $display("** Error at %0t: queue still issuing or busy in the cycle after flush",
               $time);
      errors++;
    end
    drive_cycle(make_disp(6'd42, 6'd43, 6'd17, 1'b1, 1'b1, 1'b0, 1'b0),
                make_disp(6'd44, 6'd45, 6'd18, 1'b1, 1'b1, 1'b0, 1'b0), '0, 1'b0, 1'b0);
    idle(5, 1'b0);
    finish_test("flush", e0);

    $display("Tests run %0d, cycle checks %0d, errors %0d", tests_run, checks, errors);
    if (errors == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

endmodule

// File: sources.f
rtl/iq_pkg.sv
rtl/iq_entry.sv
rtl/iq_collapse_ctrl.sv
rtl/iq_issue_select.sv
rtl/int_issue_queue.sv
tests/int_issue_queue_sva.sv
tests/int_issue_queue_tb.sv

// File: run.sh
#!/bin/sh
# Build and run the issue queue simulation with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f sources.f \
  --top-module int_issue_queue_tb -o int_issue_queue_sim

./obj_dir/int_issue_queue_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "Verification passed" sim.log; then
  exit 0
else
  echo "Simulation did not report a pass"
  exit 1
fi
